/* all.f */
+incdir+verilog
verilog/conv_pkg.sv
verilog/mac_int.sv
verilog/row_delay_line.sv
verilog/weight_bank.sv
verilog/conv_sequencer.sv
verilog/convolver.sv
verilog/conv_top.sv
dv/clk_gen.sv
dv/conv_tb.sv

/* dv/clk_gen.sv */
////////////////////
// testbench clock source
// free-running, 100 ns period
////////////////////

`timescale 1ns/1ps

module clk_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 50;  // ns

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

/* dv/conv_tb.sv */
////////////////////
// convolution engine testbench
// directed frames checked against a window-sum model
////////////////////

`timescale 1ns/1ps

`include "conv_defines.svh"

module conv_tb
  import conv_pkg::*;
();

  localparam int K          = `CONV_KERNEL_SIZE;
  localparam int NW         = K * K;
  localparam int MAXN       = `CONV_MAX_SIZE;
  localparam int WAIT_LIMIT = 4000;  // cycles per wait

  logic    clk_i;
  logic    rst_i;
  logic    en_i;
  pixel_t  data_i;
  size_t   matrix_size_i;
  stride_t stride_i;
  logic    wgt_we_i;
  weight_t wgt_data_i;
  acc_t    conv_o;
  logic    valid_conv_o;
  logic    end_conv_o;

  int img [MAXN][MAXN];  // current frame pixels
  int wgt [NW];          // current kernel, row-major
  int exp_q [$];
  int got_q [$];
  int ref_q [$];
  int end_count  = 0;
  int err_count  = 0;
  int test_count = 0;
  int fail_count = 0;
  int test_errs;
  int test_base;

  clk_gen u_clk (
    .clk_o (clk_i)
  );

  conv_top DUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .en_i          (en_i),
    .data_i        (data_i),
    .matrix_size_i (matrix_size_i),
    .stride_i      (stride_i),
    .wgt_we_i      (wgt_we_i),
    .wgt_data_i    (wgt_data_i),
    .conv_o        (conv_o),
    .valid_conv_o  (valid_conv_o),
    .end_conv_o    (end_conv_o)
  );

  // collect valid window sums and end pulses
  always @(negedge clk_i) begin
    if (valid_conv_o) got_q.push_back(int'(conv_o));
    if (end_conv_o) end_count++;
  end

  task automatic compare_value(input string what, input int got, input int exp);
    if (got != exp) begin
      err_count++;
      $display("** Error at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic start_test();
    exp_q.delete();
    got_q.delete();
    test_errs = err_count;
    test_base = end_count;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (err_count == test_errs) begin
      $display("test %s: ok, %0d outputs", name, got_q.size());
    end else begin
      fail_count++;
      $display("test %s: FAILED with %0d errors", name, err_count - test_errs);
    end
  endtask

  task automatic random_weights();
    for (int k = 0; k < NW; k++) begin
      wgt[k] = int'(weight_t'($urandom));
    end
  endtask

  task automatic fill_image(input int n);
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        img[r][c] = int'(pixel_t'($urandom));
      end
    end
  endtask

  task automatic load_weights();
    for (int k = 0; k < NW; k++) begin
      @(negedge clk_i);
      wgt_we_i   = 1'b1;
      wgt_data_i = weight_t'(wgt[k]);
    end
    @(negedge clk_i);
    wgt_we_i = 1'b0;
  endtask

  task automatic set_frame(input int n, input int s);
    @(negedge clk_i);
    matrix_size_i = size_t'(n);
    stride_i      = stride_t'(s);
  endtask

  // window sums on the stride grid, wrapped to the sum width
  task automatic add_expected(input int n, input int s);
    int sum;
    for (int r = K - 1; r < n; r++) begin
      for (int c = K - 1; c < n; c++) begin
        if (((r - K + 1) % s == 0) && ((c - K + 1) % s == 0)) begin
          sum = 0;
          for (int i = 0; i < K; i++) begin
            for (int j = 0; j < K; j++) begin
              sum += wgt[i*K + j] * img[r-K+1+i][c-K+1+j];
            end
          end
          exp_q.push_back(int'(acc_t'(sum)));
        end
      end
    end
  endtask

  task automatic drive_frame(input int n, input bit gaps);
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        if (gaps && ($urandom % 3 == 0)) begin
          repeat (1 + $urandom % 3) begin
            @(negedge clk_i);
            en_i   = 1'b0;
            data_i = pixel_t'($urandom);  // junk while stalled
          end
        end
        @(negedge clk_i);
        en_i   = 1'b1;
        data_i = pixel_t'(img[r][c]);
      end
    end
  endtask

  task automatic end_stream();
    @(negedge clk_i);
    en_i = 1'b0;
  endtask

  // wait for the end pulses, then make sure the outputs stay quiet
  task automatic wait_frames(input int target);
    int cycles;
    int seen;
    cycles = 0;
    while ((end_count < target) && (cycles < WAIT_LIMIT)) begin
      @(posedge clk_i);
      cycles++;
    end
    if (end_count < target) begin
      err_count++;
      $display("timeout: end of frame not seen within %0d cycles at %0d ns", cycles, $time);
    end
    seen = got_q.size();
    repeat (5) @(posedge clk_i);
    compare_value("valid outputs after end of frame", got_q.size(), seen);
    compare_value("end of frame pulses", end_count, target);
  endtask

  task automatic check_outputs(input string name);
    compare_value({name, " output count"}, got_q.size(), exp_q.size());
    for (int k = 0; (k < exp_q.size()) && (k < got_q.size()); k++) begin
      compare_value($sformatf("%s output %0d", name, k), got_q[k], exp_q[k]);
    end
  endtask

  task automatic test_identity();
    start_test();
    for (int k = 0; k < NW; k++) begin
      wgt[k] = (k == NW / 2) ? 1 : 0;
    end
    load_weights();
    set_frame(5, 1);
    fill_image(5);
    for (int r = K - 1; r < 5; r++) begin
      for (int c = K - 1; c < 5; c++) begin
        exp_q.push_back(img[r - K/2][c - K/2]);  // centre pixel
      end
    end
    drive_frame(5, 1'b0);
    end_stream();
    wait_frames(test_base + 1);
    compare_value("identity window count", got_q.size(), (5 - K + 1) * (5 - K + 1));
    check_outputs("identity");
    finish_test("identity kernel");
  endtask

  task automatic test_single(input string name, input int n, input int s);
    start_test();
    random_weights();
    load_weights();
    set_frame(n, s);
    fill_image(n);
    add_expected(n, s);
    drive_frame(n, 1'b0);
    end_stream();
    wait_frames(test_base + 1);
    compare_value({name, " grid count"}, got_q.size(),
                  ((n - K + s) / s) * ((n - K + s) / s));
    check_outputs(name);
    finish_test(name);
  endtask

  task automatic test_gaps();
    start_test();
    random_weights();
    load_weights();
    set_frame(7, 1);
    fill_image(7);
    add_expected(7, 1);
    drive_frame(7, 1'b0);
    end_stream();
    wait_frames(test_base + 1);
    ref_q = got_q;          // same frame without stalls
    got_q.delete();
    drive_frame(7, 1'b1);
    end_stream();
    wait_frames(test_base + 2);
    compare_value("gap run output count", got_q.size(), ref_q.size());
    for (int k = 0; (k < ref_q.size()) && (k < got_q.size()); k++) begin
      compare_value($sformatf("gap run output %0d", k), got_q[k], ref_q[k]);
    end
    check_outputs("gaps");
    finish_test("enable gaps");
  endtask

  task automatic test_back_to_back();
    start_test();
    random_weights();
    load_weights();
    set_frame(MAXN, 1);
    fill_image(MAXN);
    add_expected(MAXN, 1);
    drive_frame(MAXN, 1'b0);
    fill_image(MAXN);       // next frame follows with no idle cycle
    add_expected(MAXN, 1);
    drive_frame(MAXN, 1'b0);
    end_stream();
    wait_frames(test_base + 2);
    check_outputs("back to back");
    finish_test("full size back to back");
  endtask

  task automatic test_reload();
    start_test();
    random_weights();
    load_weights();
    set_frame(6, 1);
    fill_image(6);
    add_expected(6, 1);
    drive_frame(6, 1'b0);
    end_stream();
    wait_frames(test_base + 1);
    random_weights();
    load_weights();
    fill_image(6);
    add_expected(6, 1);
    drive_frame(6, 1'b0);
    end_stream();
    wait_frames(test_base + 2);
    check_outputs("reload");
    finish_test("weight reload");
  endtask

  initial begin
    void'($urandom(38));
    rst_i         = 1'b1;
    en_i          = 1'b0;
    data_i        = '0;
    matrix_size_i = size_t'(5);
    stride_i      = stride_t'(1);
    wgt_we_i      = 1'b0;
    wgt_data_i    = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_identity();
    test_single("random kernel", 8, 1);
    test_single("stride two", 9, 2);
    test_gaps();
    test_back_to_back();
    test_reload();

    $display("tests run %0d, tests failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the convolution testbench with Verilator, run it, check the log

verilator --binary --timing -f all.f --top-module conv_tb -o conv_sim > build.log 2>&1 \
  && ./obj_dir/conv_sim > sim.log 2>&1 \
  || { echo "build or run error, see build.log and sim.log"; exit 1; }

grep -qx "Simulation passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }

/* verilog/conv_defines.svh */
////////////////////
// convolution engine build-time sizes
// kernel edge, pixel width and largest image edge
////////////////////

`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// kernel edge K, the window is K x K
`define CONV_KERNEL_SIZE 3

// width of one pixel and of one weight
`define CONV_BITS 8

// largest image edge the row delay lines can hold
`define CONV_MAX_SIZE 16

// width of image size and position fields
`define CONV_SIZE_BITS 14

`endif

/* verilog/conv_pkg.sv */
////////////////////
// convolution engine types
// vector typedefs and sequencer states
////////////////////

`include "conv_defines.svh"

package conv_pkg;

  typedef logic signed [`CONV_BITS-1:0] pixel_t;     // one image pixel
  typedef logic signed [`CONV_BITS-1:0] weight_t;    // one kernel weight
  typedef logic signed [2*`CONV_BITS-1:0] acc_t;     // partial or final window sum

  typedef logic [`CONV_SIZE_BITS-1:0] size_t;        // image edge or position
  typedef logic [5:0] stride_t;                      // stride, 1 to 63

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // waiting for the first pixel of a frame
    RUN  = 2'd1,  // frame in progress
    DONE = 2'd2   // last pixel taken, end pulse out
  } seq_state_e;

endpackage

/* verilog/conv_sequencer.sv */
////////////////////
// convolution sequencer
// pixel position, stride grid, valid and end of frame
////////////////////

`timescale 1ns/1ps

`include "conv_defines.svh"

module conv_sequencer
  import conv_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    en_i,
  input  size_t   matrix_size_i,
  input  stride_t stride_i,
  output logic    valid_conv_o,
  output logic    end_conv_o
);

  localparam size_t KS_M1 = size_t'(`CONV_KERNEL_SIZE - 1);

  seq_state_e state_q;
  seq_state_e state_d;
  size_t      row_q;       // row of the next pixel
  size_t      col_q;       // column of the next pixel
  stride_t    row_ph_q;    // row offset from the stride grid
  stride_t    col_ph_q;    // column offset from the stride grid
  size_t      last_idx;
  stride_t    stride_last;
  logic       row_end;
  logic       frame_end;
  logic       in_window;
  logic       on_grid;

  assign last_idx    = matrix_size_i - size_t'(1);
  assign stride_last = stride_i - stride_t'(1);
  assign row_end     = (col_q == last_idx);
  assign frame_end   = row_end && (row_q == last_idx);
  assign in_window   = (row_q >= KS_M1) && (col_q >= KS_M1);  // full window present
  assign on_grid     = (row_ph_q == '0) && (col_ph_q == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (en_i) state_d = frame_end ? DONE : RUN;
      end
      RUN: begin
        if (en_i && frame_end) state_d = DONE;
      end
      DONE: begin
        // back-to-back frame starts straight away
        if (en_i) state_d = frame_end ? DONE : RUN;
        else state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  assign end_conv_o = (state_q == DONE);  // one cycle after the last pixel

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q      <= IDLE;
      row_q        <= '0;
      col_q        <= '0;
      row_ph_q     <= '0;
      col_ph_q     <= '0;
      valid_conv_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_conv_o <= en_i && in_window && on_grid;  // one-cycle pulses
      if (en_i) begin
        if (row_end) begin
          col_q    <= '0;
          col_ph_q <= '0;
          if (frame_end) begin
            row_q    <= '0;  // ready for next frame
            row_ph_q <= '0;
          end else begin
            row_q <= row_q + size_t'(1);
            if (row_q >= KS_M1) begin
              row_ph_q <= (row_ph_q == stride_last) ? '0 : row_ph_q + stride_t'(1);
            end
          end
        end else begin
          col_q <= col_q + size_t'(1);
          if (col_q >= KS_M1) begin
            col_ph_q <= (col_ph_q == stride_last) ? '0 : col_ph_q + stride_t'(1);
          end
        end
      end
    end
  end

endmodule

/* verilog/conv_top.sv */
////////////////////
// streaming 2-D convolution engine top
////////////////////

`timescale 1ns/1ps

`include "conv_defines.svh"

module conv_top
  import conv_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    en_i,
  input  pixel_t  data_i,
  input  size_t   matrix_size_i,
  input  stride_t stride_i,
  input  logic    wgt_we_i,
  input  weight_t wgt_data_i,
  output acc_t    conv_o,
  output logic    valid_conv_o,
  output logic    end_conv_o
);

  weight_t weights [`CONV_KERNEL_SIZE*`CONV_KERNEL_SIZE];

  weight_bank u_weight_bank (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wgt_we_i   (wgt_we_i),
    .wgt_data_i (wgt_data_i),
    .weights_o  (weights)
  );

  convolver u_convolver (
    .clk_i         (clk_i),
    .en_i          (en_i),
    .data_i        (data_i),
    .matrix_size_i (matrix_size_i),
    .weights_i     (weights),
    .conv_o        (conv_o)
  );

  conv_sequencer u_sequencer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .en_i          (en_i),
    .matrix_size_i (matrix_size_i),
    .stride_i      (stride_i),
    .valid_conv_o  (valid_conv_o),
    .end_conv_o    (end_conv_o)
  );

endmodule

/* verilog/convolver.sv */
////////////////////
// K x K transposed-form convolver
// MAC chain with row delay lines between kernel rows
////////////////////

`timescale 1ns/1ps

`include "conv_defines.svh"

module convolver
  import conv_pkg::*;
(
  input  logic    clk_i,
  input  logic    en_i,
  input  pixel_t  data_i,
  input  size_t   matrix_size_i,
  input  weight_t weights_i [`CONV_KERNEL_SIZE*`CONV_KERNEL_SIZE],
  output acc_t    conv_o
);

  localparam int K  = `CONV_KERNEL_SIZE;
  localparam int NW = K * K;

  acc_t mac_w [NW];    // stage outputs
  acc_t add_w [NW];    // stage sum inputs
  acc_t row_w [K-1];   // delayed end-of-row sums

  // stage s = i*K+j sees window pixel (i,j) when the
  // last stage sees the bottom-right pixel
  for (genvar s = 0; s < NW; s++) begin : g_mac
    if (s == 0) begin : g_first
      assign add_w[s] = '0;
    end else if ((s % K) == 0) begin : g_row_start
      assign add_w[s] = row_w[s/K - 1];  // from previous kernel row
    end else begin : g_middle
      assign add_w[s] = mac_w[s-1];
    end

    mac_int u_mac (
      .clk_i   (clk_i),
      .en_i    (en_i),
      .value_i (data_i),      // broadcast to every stage
      .mult_i  (weights_i[s]),
      .add_i   (add_w[s]),
      .mac_o   (mac_w[s])
    );
  end

  // one delay line after each kernel row but the last
  for (genvar r = 0; r < K - 1; r++) begin : g_row
    row_delay_line u_dly (
      .clk_i         (clk_i),
      .en_i          (en_i),
      .matrix_size_i (matrix_size_i),
      .data_i        (mac_w[r*K + K - 1]),
      .data_o        (row_w[r])
    );
  end

  assign conv_o = mac_w[NW-1];  // full window sum

endmodule

/* verilog/mac_int.sv */
////////////////////
// multiply-accumulate stage
////////////////////

`timescale 1ns/1ps

module mac_int
  import conv_pkg::*;
(
  input  logic    clk_i,
  input  logic    en_i,
  input  pixel_t  value_i,
  input  weight_t mult_i,
  input  acc_t    add_i,
  output acc_t    mac_o
);

  // product plus the incoming partial sum
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      mac_o <= (value_i * mult_i) + add_i;  // signed, full acc width
    end
  end

endmodule

/* verilog/row_delay_line.sv */
////////////////////
// row delay line for partial sums
// delays by image size minus K enabled cycles
////////////////////

`timescale 1ns/1ps

`include "conv_defines.svh"

module row_delay_line
  import conv_pkg::*;
(
  input  logic  clk_i,
  input  logic  en_i,
  input  size_t matrix_size_i,
  input  acc_t  data_i,
  output acc_t  data_o
);

  localparam int DIFF  = `CONV_MAX_SIZE - `CONV_KERNEL_SIZE;
  localparam int DEPTH = (DIFF > 0) ? DIFF : 1;
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam size_t KS = size_t'(`CONV_KERNEL_SIZE);

  acc_t             store_q [DEPTH];  // store_q[0] is one cycle old
  size_t            tap_full;
  logic [IDX_W-1:0] tap_idx;

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      store_q[0] <= data_i;
      for (int k = 1; k < DEPTH; k++) begin
        store_q[k] <= store_q[k-1];
      end
    end
  end

  assign tap_full = matrix_size_i - KS - size_t'(1);
  assign tap_idx  = tap_full[IDX_W-1:0];  // N - K - 1 fits the line depth

  // image as wide as the kernel needs no extra delay
  assign data_o = (matrix_size_i == KS) ? data_i : store_q[tap_idx];

endmodule

/* verilog/weight_bank.sv */
////////////////////
// kernel weight bank
// serial loader, row-major window order
////////////////////

`timescale 1ns/1ps

`include "conv_defines.svh"

module weight_bank
  import conv_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    wgt_we_i,
  input  weight_t wgt_data_i,
  output weight_t weights_o [`CONV_KERNEL_SIZE*`CONV_KERNEL_SIZE]
);

  localparam int NW     = `CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE;
  localparam int PTR_W  = (NW > 1) ? $clog2(NW) : 1;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(NW - 1);

  logic [PTR_W-1:0] ptr_q;     // next weight to write
  weight_t          wgt_q [NW];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ptr_q <= '0;
      for (int k = 0; k < NW; k++) begin
        wgt_q[k] <= '0;
      end
    end else if (wgt_we_i) begin
      wgt_q[ptr_q] <= wgt_data_i;
      ptr_q        <= (ptr_q == PTR_LAST) ? '0 : ptr_q + PTR_W'(1);  // wrap after K*K
    end
  end

  always_comb begin
    for (int k = 0; k < NW; k++) begin
      weights_o[k] = wgt_q[k];
    end
  end

endmodule
